/* src/core_pkg.sv */
package core_pkg;

    // data and pc width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [3:0]      alu_op_t;
    typedef logic [2:0]      ext_op_t;
    typedef logic [1:0]      src2_sel_t;
    typedef logic [1:0]      brc_t;

    // alu operations
    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_SLL   = 4'd2;
    localparam alu_op_t ALU_SLT   = 4'd3;
    localparam alu_op_t ALU_SLTU  = 4'd4;
    localparam alu_op_t ALU_XOR   = 4'd5;
    localparam alu_op_t ALU_SRL   = 4'd6;
    localparam alu_op_t ALU_SRA   = 4'd7;
    localparam alu_op_t ALU_OR    = 4'd8;
    localparam alu_op_t ALU_AND   = 4'd9;
    // operand b straight through, for lui
    localparam alu_op_t ALU_PASSB = 4'd10;

    // immediate formats
    localparam ext_op_t EXT_I = 3'd0;
    localparam ext_op_t EXT_S = 3'd1;
    localparam ext_op_t EXT_B = 3'd2;
    localparam ext_op_t EXT_U = 3'd3;
    localparam ext_op_t EXT_J = 3'd4;

    // operand b sources
    localparam src2_sel_t SRC2_REG  = 2'd0;
    localparam src2_sel_t SRC2_IMM  = 2'd1;
    localparam src2_sel_t SRC2_FOUR = 2'd2;

    // control flow kinds
    localparam brc_t BRC_NONE   = 2'd0;
    localparam brc_t BRC_BRANCH = 2'd1;
    localparam brc_t BRC_JAL    = 2'd2;
    localparam brc_t BRC_JALR   = 2'd3;

    // branch funct3 codes
    localparam logic [2:0] BR_BEQ  = 3'b000;
    localparam logic [2:0] BR_BNE  = 3'b001;
    localparam logic [2:0] BR_BLT  = 3'b100;
    localparam logic [2:0] BR_BGE  = 3'b101;
    localparam logic [2:0] BR_BLTU = 3'b110;
    localparam logic [2:0] BR_BGEU = 3'b111;

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam instr_t EBREAK_INSTR = 32'h0010_0073;

endpackage

/* src/id_ex_if.sv */
`timescale 1ns/1ps

interface id_ex_if import core_pkg::*; ();
    logic      valid;
    word_t     pc;
    // operands as read in decode, before forwarding
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    // high picks pc as operand a
    logic      src1sel;
    src2_sel_t src2sel;
    alu_op_t   alu_op;
    logic [2:0] funct3;
    brc_t      brc;
    reg_idx_t  rd;
    logic      wb_en;
    logic      ebreak;
    // kill the next decoded instruction
    logic      squash;

    modport dec (
        output valid, pc, rs1_val, rs2_val, imm, rs1_idx, rs2_idx,
        output src1sel, src2sel, alu_op, funct3, brc, rd, wb_en, ebreak,
        input  squash
    );

    modport exe (
        input  valid, pc, rs1_val, rs2_val, imm, rs1_idx, rs2_idx,
        input  src1sel, src2sel, alu_op, funct3, brc, rd, wb_en, ebreak,
        output squash
    );
endinterface

/* src/ex_wb_if.sv */
`timescale 1ns/1ps

interface ex_wb_if import core_pkg::*; ();
    // execute result, not yet registered
    logic     valid;
    reg_idx_t rd;
    logic     wb_en;
    word_t    result;
    word_t    pc;
    logic     ebreak;
    // registered write port out of the result step
    logic     wr_en;
    reg_idx_t wr_rd;
    word_t    wr_data;

    modport exe (
        output valid, rd, wb_en, result, pc, ebreak,
        input  wr_en, wr_rd, wr_data
    );

    modport res (
        input  valid, rd, wb_en, result, pc, ebreak,
        output wr_en, wr_rd, wr_data
    );

    // register file write side
    modport dec (
        input wr_en, wr_rd, wr_data
    );
endinterface

/* src/decoder.sv */
`timescale 1ns/1ps

module decoder import core_pkg::*; (
    input  instr_t    instr_i,
    output ext_op_t   ext_op_o,
    output logic      src1sel_o,
    output src2_sel_t src2sel_o,
    output alu_op_t   aluctr_o,
    output brc_t      brc_o,
    output logic      wb_en_o,
    output reg_idx_t  rs1_idx_o,
    output reg_idx_t  rs2_idx_o,
    output reg_idx_t  rd_o,
    output logic      ebreak_o
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    alu_op_t    alu_f3;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    // bit 30 flags sub and sra
    assign funct7_b5 = instr_i[30];

    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];
    assign rd_o      = instr_i[11:7];

    // funct3 mapping shared by reg and imm forms
    always_comb begin
        case (funct3)
            3'b000:  alu_f3 = (opcode == OP_REG && funct7_b5) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_f3 = ALU_SLL;
            3'b010:  alu_f3 = ALU_SLT;
            3'b011:  alu_f3 = ALU_SLTU;
            3'b100:  alu_f3 = ALU_XOR;
            3'b101:  alu_f3 = funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  alu_f3 = ALU_OR;
            default: alu_f3 = ALU_AND;
        endcase
    end

    always_comb begin
        // defaults give a no-write nop
        ext_op_o  = EXT_I;
        src1sel_o = 1'b0;
        src2sel_o = SRC2_REG;
        aluctr_o  = ALU_ADD;
        brc_o     = BRC_NONE;
        wb_en_o   = 1'b0;
        ebreak_o  = 1'b0;
        case (opcode)
            OP_REG: begin
                aluctr_o = alu_f3;
                wb_en_o  = 1'b1;
            end
            OP_IMM: begin
                src2sel_o = SRC2_IMM;
                aluctr_o  = alu_f3;
                wb_en_o   = 1'b1;
            end
            OP_LUI: begin
                ext_op_o  = EXT_U;
                src2sel_o = SRC2_IMM;
                aluctr_o  = ALU_PASSB;
                wb_en_o   = 1'b1;
            end
            OP_AUIPC: begin
                ext_op_o  = EXT_U;
                src1sel_o = 1'b1;
                src2sel_o = SRC2_IMM;
                wb_en_o   = 1'b1;
            end
            // links compute pc + 4 in the alu
            OP_JAL: begin
                ext_op_o  = EXT_J;
                src1sel_o = 1'b1;
                src2sel_o = SRC2_FOUR;
                brc_o     = BRC_JAL;
                wb_en_o   = 1'b1;
            end
            OP_JALR: begin
                src1sel_o = 1'b1;
                src2sel_o = SRC2_FOUR;
                brc_o     = BRC_JALR;
                wb_en_o   = 1'b1;
            end
            OP_BRANCH: begin
                ext_op_o = EXT_B;
                aluctr_o = ALU_SUB;
                brc_o    = BRC_BRANCH;
            end
            // only ebreak is honoured here
            OP_SYSTEM: begin
                ebreak_o = (instr_i == EBREAK_INSTR);
            end
            default: begin
                wb_en_o = 1'b0;
            end
        endcase
    end
endmodule

/* src/imm_ext.sv */
`timescale 1ns/1ps

module imm_ext import core_pkg::*; (
    input  logic [24:0] instr_imm_i,
    input  ext_op_t     ext_op_i,
    output word_t       imm_o
);
    // rebuilt word so bit numbers match the isa manual
    instr_t ins;

    assign ins = {instr_imm_i, 7'b0};

    always_comb begin
        case (ext_op_i)
            EXT_S: begin
                imm_o = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            // branch offsets are in halfwords
            EXT_B: begin
                imm_o = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            EXT_U: begin
                imm_o = {ins[31:12], 12'b0};
            end
            EXT_J: begin
                imm_o = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            // i format and anything unknown
            default: begin
                imm_o = {{20{ins[31]}}, ins[31:20]};
            end
        endcase
    end
endmodule

/* src/regfile.sv */
`timescale 1ns/1ps

module regfile import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    input  reg_idx_t rs1_addr_i,
    input  reg_idx_t rs2_addr_i,
    input  logic     wr_en_i,
    input  reg_idx_t wr_addr_i,
    input  word_t    wr_data_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o
);
    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // write-through so a same-cycle write is seen by decode
    always_comb begin
        if (rs1_addr_i == '0) begin
            rs1_data_o = '0;
        end else if (wr_en_i && wr_addr_i == rs1_addr_i) begin
            rs1_data_o = wr_data_i;
        end else begin
            rs1_data_o = regs[rs1_addr_i];
        end
        if (rs2_addr_i == '0) begin
            rs2_data_o = '0;
        end else if (wr_en_i && wr_addr_i == rs2_addr_i) begin
            rs2_data_o = wr_data_i;
        end else begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

    // a stored value reads back the cycle after its write
    a_read_back: assert property (@(posedge clk) disable iff (rst_i)
        $past(wr_en_i) && $past(wr_addr_i) != '0 && rs1_addr_i == $past(wr_addr_i) &&
        !(wr_en_i && wr_addr_i == rs1_addr_i) |-> rs1_data_o == $past(wr_data_i));
endmodule

/* src/id_stage.sv */
`timescale 1ns/1ps

module id_stage import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_i,
    input  logic   instr_valid_i,
    input  instr_t instr_i,
    input  word_t  pc_i,
    id_ex_if.dec   id_ex,
    ex_wb_if.dec   wb
);
    ext_op_t   ext_op;
    logic      src1sel;
    src2_sel_t src2sel;
    alu_op_t   aluctr;
    brc_t      brc;
    logic      wb_en;
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    reg_idx_t  rd;
    logic      ebreak;
    word_t     imm;
    word_t     rs1_val;
    word_t     rs2_val;

    decoder decoder_u (
        .instr_i   (instr_i),
        .ext_op_o  (ext_op),
        .src1sel_o (src1sel),
        .src2sel_o (src2sel),
        .aluctr_o  (aluctr),
        .brc_o     (brc),
        .wb_en_o   (wb_en),
        .rs1_idx_o (rs1_idx),
        .rs2_idx_o (rs2_idx),
        .rd_o      (rd),
        .ebreak_o  (ebreak)
    );

    imm_ext imm_ext_u (
        .instr_imm_i (instr_i[31:7]),
        .ext_op_i    (ext_op),
        .imm_o       (imm)
    );

    // write port comes back from the result step
    regfile regfile_u (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_idx),
        .rs2_addr_i (rs2_idx),
        .wr_en_i    (wb.wr_en),
        .wr_addr_i  (wb.wr_rd),
        .wr_data_i  (wb.wr_data),
        .rs1_data_o (rs1_val),
        .rs2_data_o (rs2_val)
    );

    // valid: dropped on reset or when execute redirects
    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= instr_valid_i & ~id_ex.squash;
        end
    end

    // payload loads every cycle
    always_ff @(posedge clk) begin
        id_ex.pc      <= pc_i;
        id_ex.rs1_val <= rs1_val;
        id_ex.rs2_val <= rs2_val;
        id_ex.imm     <= imm;
        id_ex.rs1_idx <= rs1_idx;
        id_ex.rs2_idx <= rs2_idx;
        id_ex.src1sel <= src1sel;
        id_ex.src2sel <= src2sel;
        id_ex.alu_op  <= aluctr;
        id_ex.funct3  <= instr_i[14:12];
        id_ex.brc     <= brc;
        id_ex.rd      <= rd;
        id_ex.wb_en   <= wb_en;
        id_ex.ebreak  <= ebreak;
    end
endmodule

/* src/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage import core_pkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    id_ex_if.exe  id_ex,
    ex_wb_if.exe  ex_wb,
    output logic  redirect_o,
    output word_t redirect_pc_o
);
    logic  fwd1;
    logic  fwd2;
    word_t rs1;
    word_t rs2;
    word_t op_a;
    word_t op_b;
    word_t alu_out;
    logic  [4:0] shamt;
    logic  br_cond;
    logic  take;
    word_t jalr_sum;

    // producer one older sits in the result register
    assign fwd1 = ex_wb.wr_en && id_ex.rs1_idx != '0 && ex_wb.wr_rd == id_ex.rs1_idx;
    assign fwd2 = ex_wb.wr_en && id_ex.rs2_idx != '0 && ex_wb.wr_rd == id_ex.rs2_idx;
    assign rs1  = fwd1 ? ex_wb.wr_data : id_ex.rs1_val;
    assign rs2  = fwd2 ? ex_wb.wr_data : id_ex.rs2_val;

    // operand select
    assign op_a = id_ex.src1sel ? id_ex.pc : rs1;
    always_comb begin
        case (id_ex.src2sel)
            SRC2_IMM:  op_b = id_ex.imm;
            SRC2_FOUR: op_b = word_t'(4);
            default:   op_b = rs2;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB:   alu_out = op_a - op_b;
            ALU_SLL:   alu_out = op_a << shamt;
            ALU_SLT:   alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:  alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:   alu_out = op_a ^ op_b;
            ALU_SRL:   alu_out = op_a >> shamt;
            ALU_SRA:   alu_out = $signed(op_a) >>> shamt;
            ALU_OR:    alu_out = op_a | op_b;
            ALU_AND:   alu_out = op_a & op_b;
            ALU_PASSB: alu_out = op_b;
            default:   alu_out = op_a + op_b;
        endcase
    end

    // branch compare on forwarded registers
    always_comb begin
        case (id_ex.funct3)
            BR_BEQ:  br_cond = (rs1 == rs2);
            BR_BNE:  br_cond = (rs1 != rs2);
            BR_BLT:  br_cond = $signed(rs1) < $signed(rs2);
            BR_BGE:  br_cond = $signed(rs1) >= $signed(rs2);
            BR_BLTU: br_cond = rs1 < rs2;
            BR_BGEU: br_cond = rs1 >= rs2;
            default: br_cond = 1'b0;
        endcase
    end

    assign take = id_ex.valid && (id_ex.brc == BRC_JAL || id_ex.brc == BRC_JALR ||
                                  (id_ex.brc == BRC_BRANCH && br_cond));

    // jalr target drops bit 0
    assign jalr_sum      = rs1 + id_ex.imm;
    assign redirect_pc_o = (id_ex.brc == BRC_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                   : id_ex.pc + id_ex.imm;
    assign redirect_o    = take;
    assign id_ex.squash  = take;

    // to the result step
    assign ex_wb.valid  = id_ex.valid;
    assign ex_wb.rd     = id_ex.rd;
    assign ex_wb.wb_en  = id_ex.wb_en;
    assign ex_wb.result = alu_out;
    assign ex_wb.pc     = id_ex.pc;
    assign ex_wb.ebreak = id_ex.ebreak;

    a_target_aligned: assert property (@(posedge clk) disable iff (rst_i)
        redirect_o |-> redirect_pc_o[1:0] == 2'b00);
endmodule

/* src/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    ex_wb_if.res     ex_wb,
    output logic     retire_o,
    output word_t    retire_pc_o,
    output reg_idx_t retire_rd_o,
    output logic     retire_we_o,
    output word_t    retire_data_o,
    output logic     halt_o
);
    logic     valid_q;
    logic     halt_q;
    logic     halting;
    reg_idx_t rd_q;
    logic     we_q;
    word_t    data_q;
    word_t    pc_q;
    logic     ebreak_q;

    // ebreak retiring now blocks the next one too
    assign halting = halt_q | (valid_q & ebreak_q);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            halt_q  <= 1'b0;
        end else begin
            valid_q <= ex_wb.valid & ~halting;
            if (valid_q && ebreak_q) begin
                halt_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_wb.valid) begin
            rd_q     <= ex_wb.rd;
            we_q     <= ex_wb.wb_en;
            data_q   <= ex_wb.result;
            pc_q     <= ex_wb.pc;
            ebreak_q <= ex_wb.ebreak;
        end
    end

    // x0 writes never reach the register file
    assign ex_wb.wr_en   = valid_q & we_q & (rd_q != '0);
    assign ex_wb.wr_rd   = rd_q;
    assign ex_wb.wr_data = data_q;

    assign retire_o      = valid_q;
    assign retire_pc_o   = pc_q;
    assign retire_rd_o   = rd_q;
    assign retire_we_o   = ex_wb.wr_en;
    assign retire_data_o = data_q;
    assign halt_o        = halt_q;

    a_quiet_after_halt: assert property (@(posedge clk) disable iff (rst_i)
        halt_o |-> !retire_o);
endmodule

/* src/core_top.sv */
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     instr_valid_i,
    input  instr_t   instr_i,
    input  word_t    pc_i,
    output logic     redirect_o,
    output word_t    redirect_pc_o,
    output logic     retire_o,
    output word_t    retire_pc_o,
    output reg_idx_t retire_rd_o,
    output logic     retire_we_o,
    output word_t    retire_data_o,
    output logic     halt_o
);
    // decode to execute, squash back
    id_ex_if id_ex ();
    // execute to result, write port back
    ex_wb_if ex_wb ();

    id_stage id_stage_u (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .id_ex         (id_ex.dec),
        .wb            (ex_wb.dec)
    );

    ex_stage ex_stage_u (
        .clk           (clk),
        .rst_i         (rst_i),
        .id_ex         (id_ex.exe),
        .ex_wb         (ex_wb.exe),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    wb_stage wb_stage_u (
        .clk           (clk),
        .rst_i         (rst_i),
        .ex_wb         (ex_wb.res),
        .retire_o      (retire_o),
        .retire_pc_o   (retire_pc_o),
        .retire_rd_o   (retire_rd_o),
        .retire_we_o   (retire_we_o),
        .retire_data_o (retire_data_o),
        .halt_o        (halt_o)
    );
endmodule

/* sim/tb_core.sv */
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

    localparam int MEM_WORDS = 256;

    logic     clk = 1'b0;
    logic     rst_i;
    logic     instr_valid_i;
    instr_t   instr_i;
    word_t    pc_i;
    logic     redirect_o;
    word_t    redirect_pc_o;
    logic     retire_o;
    word_t    retire_pc_o;
    reg_idx_t retire_rd_o;
    logic     retire_we_o;
    word_t    retire_data_o;
    logic     halt_o;

    // program image indexed by pc/4
    instr_t   prog [0:MEM_WORDS-1];
    int       prog_len;
    // expected retire stream in program order
    word_t    exp_pc [0:MEM_WORDS-1];
    reg_idx_t exp_rd [0:MEM_WORDS-1];
    logic     exp_we [0:MEM_WORDS-1];
    word_t    exp_data [0:MEM_WORDS-1];
    logic     exp_taken [0:MEM_WORDS-1];
    word_t    exp_tgt [0:MEM_WORDS-1];
    int       n_exp;
    int       ret_idx;
    int       cycles;
    int       limit;
    int       seed;
    word_t    fetch_pc;
    // architectural registers of the model
    word_t    shadow [0:31];

    core_top u_core_top (
        .clk           (clk),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .retire_o      (retire_o),
        .retire_pc_o   (retire_pc_o),
        .retire_rd_o   (retire_rd_o),
        .retire_we_o   (retire_we_o),
        .retire_data_o (retire_data_o),
        .halt_o        (halt_o)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    // instruction encoders
    function automatic instr_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                      input logic [2:0] f3, input reg_idx_t rd,
                                      input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input logic [2:0] f3,
                                      input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic instr_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                      input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic instr_t b_type(input logic [12:0] off, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic instr_t j_type(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic instr_t fetch_word(input word_t pc);
        if (int'(pc >> 2) < prog_len) begin
            return prog[pc >> 2];
        end
        // past the end comes a write that must never retire
        return i_type(12'd1, 5'd1, 3'b000, 5'd1, OP_IMM);
    endfunction

    // rv32i arithmetic on the model side
    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic append_instr(input instr_t ins);
        prog[prog_len] = ins;
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    prev1;
        reg_idx_t    prev2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        instr_t      skip_slot;
        prog_len  = 0;
        // addi x7, x7, 1 sits in every slot a taken jump skips
        skip_slot = i_type(12'd1, 5'd7, 3'b000, 5'd7, OP_IMM);
        // seed x1..x7 with lui + addi pairs
        for (int r = 1; r < 8; r++) begin
            rnd = $random(seed);
            append_instr(u_type(rnd[31:12], 5'(r), OP_LUI));
            append_instr(i_type(rnd[11:0], 5'(r), 3'b000, 5'(r), OP_IMM));
        end
        // every funct3 in imm and reg form with and without bit 30
        prev1 = 5'd1;
        prev2 = 5'd2;
        for (int k = 0; k < 48; k++) begin
            rnd = $random(seed);
            rd  = {2'b00, rnd[2:0]};
            // often chain on the last two results
            rs1 = rnd[3] ? prev1 : {2'b00, rnd[6:4]};
            rs2 = rnd[7] ? prev2 : {2'b00, rnd[10:8]};
            f3  = 3'(k);
            alt = (k / 16) == 1;
            if ((k / 8) % 2 == 1) begin
                append_instr(r_type((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                                    rs2, rs1, f3, rd));
            end else begin
                imm = rnd[31:20];
                // shift immediates carry only shamt and the sra flag
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {((alt && f3 == 3'b101) ? 7'h20 : 7'h00), rnd[24:20]};
                end
                append_instr(i_type(imm, rs1, f3, rd, OP_IMM));
            end
            prev2 = prev1;
            prev1 = rd;
        end
        // x5 = -5 and x6 = 9 order differently signed and unsigned
        append_instr(i_type(12'hffb, 5'd0, 3'b000, 5'd5, OP_IMM));
        append_instr(i_type(12'd9, 5'd0, 3'b000, 5'd6, OP_IMM));
        for (int k = 0; k < 8; k++) begin
            if (k != 2 && k != 3) begin
                // pairs (x5,x6) (x6,x5) (x5,x5) give both outcomes per kind
                for (int j = 0; j < 3; j++) begin
                    rs1 = (j == 1) ? 5'd6 : 5'd5;
                    rs2 = (j == 0) ? 5'd6 : 5'd5;
                    append_instr(b_type(13'd8, rs2, rs1, 3'(k)));
                    append_instr(skip_slot);
                end
            end
        end
        rnd = $random(seed);
        append_instr(u_type(rnd[31:12], 5'd3, OP_LUI));
        append_instr(u_type(rnd[19:0], 5'd4, OP_AUIPC));
        append_instr(j_type(21'd8, 5'd1));
        append_instr(skip_slot);
        // link into x0 retires without a write
        append_instr(j_type(21'd8, 5'd0));
        append_instr(skip_slot);
        append_instr(u_type(20'd0, 5'd3, OP_AUIPC));
        // odd offset so the low target bit must drop
        append_instr(i_type(12'd13, 5'd3, 3'b000, 5'd2, OP_JALR));
        append_instr(skip_slot);
        // writes to x0 then reads one and two later
        append_instr(i_type(12'd77, 5'd1, 3'b000, 5'd0, OP_IMM));
        append_instr(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd2));
        append_instr(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        append_instr(i_type(12'd0, 5'd0, 3'b000, 5'd4, OP_IMM));
        append_instr(EBREAK_INSTR);
    endtask

    // walk the program in order, recording what must retire
    task automatic run_model();
        word_t  pc;
        word_t  a;
        word_t  b;
        word_t  res;
        word_t  nxt;
        word_t  imm_i;
        word_t  imm_b;
        word_t  imm_j;
        word_t  imm_u;
        instr_t ins;
        logic   wr;
        logic   taken;
        logic   done;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        pc    = '0;
        n_exp = 0;
        done  = 1'b0;
        while (!done && n_exp < MEM_WORDS) begin
            ins   = fetch_word(pc);
            a     = shadow[ins[19:15]];
            b     = shadow[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            imm_u = {ins[31:12], 12'b0};
            res   = '0;
            wr    = 1'b1;
            taken = 1'b0;
            nxt   = pc + 32'd4;
            case (ins[6:0])
                OP_LUI:   res = imm_u;
                OP_AUIPC: res = pc + imm_u;
                OP_JAL: begin
                    res   = pc + 32'd4;
                    taken = 1'b1;
                    nxt   = pc + imm_j;
                end
                OP_JALR: begin
                    res   = pc + 32'd4;
                    taken = 1'b1;
                    nxt   = (a + imm_i) & ~32'd1;
                end
                OP_BRANCH: begin
                    wr    = 1'b0;
                    taken = branch_taken(ins[14:12], a, b);
                    if (taken) begin
                        nxt = pc + imm_b;
                    end
                end
                OP_IMM:   res = alu_model(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
                OP_REG:   res = alu_model(ins[14:12], ins[30], a, b);
                // ebreak and anything else write nothing
                default:  wr = 1'b0;
            endcase
            exp_pc[n_exp]    = pc;
            exp_rd[n_exp]    = ins[11:7];
            exp_we[n_exp]    = wr && ins[11:7] != 5'd0;
            exp_data[n_exp]  = res;
            exp_taken[n_exp] = taken;
            exp_tgt[n_exp]   = nxt;
            n_exp++;
            if (wr && ins[11:7] != 5'd0) begin
                shadow[ins[11:7]] = res;
            end
            done = (ins == EBREAK_INSTR);
            pc   = nxt;
        end
    endtask

    // one fetch slot that steers the next slot after a redirect
    task automatic issue_next();
        instr_valid_i = 1'b1;
        instr_i       = fetch_word(fetch_pc);
        pc_i          = fetch_pc;
        if (redirect_o) begin
            fetch_pc = redirect_pc_o;
        end else begin
            fetch_pc = fetch_pc + 32'd4;
        end
    endtask

    always @(posedge clk) begin
        if (rst_i) begin
            ret_idx <= 0;
        end else if (retire_o) begin
            ret_idx <= ret_idx + 1;
        end
    end

    // run limit from the program length
    always @(posedge clk) begin
        if (rst_i) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
        if (cycles > limit) begin
            abort_run($sformatf("timeout: core did not halt within %0d cycles", limit));
        end
    end

    // retire order and pc catch a squashed slot that retires
    a_retire_pc: assert property (@(posedge clk) disable iff (rst_i)
        retire_o |-> ret_idx < n_exp && retire_pc_o == exp_pc[ret_idx])
        else abort_run($sformatf("ERROR: %0t: retire pc %h, expected %h",
                                 $time, $sampled(retire_pc_o), exp_pc[$sampled(ret_idx)]));

    a_retire_we: assert property (@(posedge clk) disable iff (rst_i)
        retire_o |-> retire_we_o == exp_we[ret_idx])
        else abort_run($sformatf("ERROR: %0t: retire_we %b at pc %h, expected %b",
                                 $time, $sampled(retire_we_o), $sampled(retire_pc_o),
                                 exp_we[$sampled(ret_idx)]));

    a_retire_val: assert property (@(posedge clk) disable iff (rst_i)
        retire_o && exp_we[ret_idx] |->
            retire_rd_o == exp_rd[ret_idx] && retire_data_o == exp_data[ret_idx])
        else abort_run($sformatf("ERROR: %0t: pc %h wrote x%0d=%h, expected x%0d=%h",
                                 $time, $sampled(retire_pc_o), $sampled(retire_rd_o),
                                 $sampled(retire_data_o), exp_rd[$sampled(ret_idx)],
                                 exp_data[$sampled(ret_idx)]));

    // redirect shows one cycle before its retire
    a_redirect: assert property (@(posedge clk) disable iff (rst_i)
        retire_o |-> $past(redirect_o) == exp_taken[ret_idx])
        else abort_run($sformatf("ERROR: %0t: redirect %b for pc %h, expected %b",
                                 $time, $past(redirect_o), $sampled(retire_pc_o),
                                 exp_taken[$sampled(ret_idx)]));

    a_redirect_pc: assert property (@(posedge clk) disable iff (rst_i)
        retire_o && exp_taken[ret_idx] |-> $past(redirect_pc_o) == exp_tgt[ret_idx])
        else abort_run($sformatf("ERROR: %0t: target %h for pc %h, expected %h",
                                 $time, $past(redirect_pc_o), $sampled(retire_pc_o),
                                 exp_tgt[$sampled(ret_idx)]));

    a_halt_quiet: assert property (@(posedge clk) disable iff (rst_i)
        halt_o |-> !retire_o && !redirect_o)
        else abort_run($sformatf("ERROR: %0t: activity after halt, retire pc %h",
                                 $time, $sampled(retire_pc_o)));

    initial begin
        seed          = 54895;
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        fetch_pc      = '0;
        build_program();
        run_model();
        limit = prog_len * 4 + 50;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        while (!halt_o) begin
            issue_next();
            @(negedge clk);
        end
        // keep feeding filler that must never retire
        repeat (20) begin
            issue_next();
            @(negedge clk);
        end
        if (ret_idx == n_exp) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run($sformatf("only %0d of %0d instructions retired before halt",
                                ret_idx, n_exp));
        end
    end
endmodule

/* filelist.f */
src/core_pkg.sv
src/id_ex_if.sv
src/ex_wb_if.sv
src/decoder.sv
src/imm_ext.sv
src/regfile.sv
src/id_stage.sv
src/ex_stage.sv
src/wb_stage.sv
src/core_top.sv
sim/tb_core.sv

/* Makefile */
# verilator build and run for the core testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module tb_core -Mdir obj_dir

# pass only if the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/Vtb_core)"; echo "$$out"; echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
